// ==== dv/tb_id_stage.sv ====
// table-driven testbench for the rv32i decode stage
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;
  import rv_id_pkg::*;

  localparam int SEED = 89992;
  localparam int TMO  = 20;  // cycles per wait

  localparam logic [1:0] M_PLAIN  = 2'd0;
  localparam logic [1:0] M_STALL  = 2'd1;  // load in execute hits rs2
  localparam logic [1:0] M_HOLD   = 2'd2;  // execute refuses for a while
  localparam logic [1:0] M_FOLLOW = 2'd3;  // next fetch arrives during redirect

  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] fetch_pc;     // fetch pc while the entry sits in decode
    logic [1:0]  mode;
    logic [31:0] follow_inst;
    bypass_t     es;
    bypass_t     ms;
    bypass_t     ws;
    logic        load_sel;
    logic [31:0] exp_rs1;
    logic [31:0] exp_rs2;
    logic [31:0] exp_imm;
    logic [4:0]  exp_rd;
    logic        exp_inv;
    logic        exp_taken;
    logic [31:0] exp_target;
  } entry_t;

  logic       i_clk;
  logic       i_rst_n;
  logic       i_fs_valid;
  fs_to_ds_t  i_fs_bus;
  logic       o_ds_allowin;
  logic       o_ds_to_es_valid;
  ds_to_es_t  o_ds_to_es_bus;
  logic       i_es_allowin;
  br_bus_t    o_br_bus;
  rf_wr_t     i_ws_to_rf_bus;
  bypass_t    i_es_bypass;
  bypass_t    i_ms_bypass;
  bypass_t    i_ws_bypass;
  logic       i_es_load_sel;

  logic [31:0] rf_model [32];
  entry_t      table_q [$];
  string       name_q [$];
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  bit          timed_out;

  id_stage DUT (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_valid       (i_fs_valid),
    .i_fs_bus         (i_fs_bus),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_to_es_bus   (o_ds_to_es_bus),
    .i_es_allowin     (i_es_allowin),
    .o_br_bus         (o_br_bus),
    .i_ws_to_rf_bus   (i_ws_to_rf_bus),
    .i_es_bypass      (i_es_bypass),
    .i_ms_bypass      (i_ms_bypass),
    .i_ws_bypass      (i_ws_bypass),
    .i_es_load_sel    (i_es_load_sel)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  // instruction words per isa format
  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  function automatic entry_t new_entry(input logic [31:0] inst, input logic [31:0] pc,
                                       input logic [31:0] rs1, input logic [31:0] rs2,
                                       input logic [31:0] imm, input logic [4:0] rd);
    entry_t e;
    e          = '0;
    e.inst     = inst;
    e.pc       = pc;
    e.fetch_pc = pc + 32'd4;  // sequential fetch
    e.exp_rs1  = rs1;
    e.exp_rs2  = rs2;
    e.exp_imm  = imm;
    e.exp_rd   = rd;
    return e;
  endfunction

  task automatic add_entry(input string name, input entry_t e);
    name_q.push_back(name);
    table_q.push_back(e);
  endtask

  task automatic check_eq(input string sig, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %s expected %h got %h", sig, exp, got);
    end
  endtask

  task automatic report(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %-12s ok", name);
    end else begin
      tests_failed++;
      $display("test %-12s failed, %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic wait_allowin(output bit ok);
    int n;
    n = 0;
    while (!o_ds_allowin && n < TMO) begin
      @(negedge i_clk);
      #1;
      n++;
    end
    ok = o_ds_allowin;
    if (!ok) begin
      timed_out = 1'b1;
      $display("timeout: decode stage did not accept an instruction in %0d cycles", TMO);
    end
  endtask

  task automatic poll_out_valid(output bit ok);
    int n;
    n = 0;
    while (!o_ds_to_es_valid && n < TMO) begin
      @(negedge i_clk);
      #1;
      n++;
    end
    ok = o_ds_to_es_valid;
    if (!ok) begin
      timed_out = 1'b1;
      $display("timeout: decode stage gave no valid output in %0d cycles", TMO);
    end
  endtask

  task automatic fill_registers();
    logic [31:0] val;
    for (int r = 0; r < 32; r++) begin
      @(negedge i_clk);
      val = $urandom();
      if (r == 0) begin
        val = val | 32'd1;  // nonzero write to x0
      end
      i_ws_to_rf_bus = {1'b1, 5'(r), val};
      rf_model[r]    = (r == 0) ? 32'd0 : val;
    end
    @(negedge i_clk);
    i_ws_to_rf_bus = '0;
  endtask

  task automatic build_table();
    entry_t      e;
    logic [31:0] tgt;
    e = new_entry(r_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OPC_OP), 32'h100,
                  rf_model[1], rf_model[2], 32'd0, 5'd3);
    add_entry("add_rf", e);
    e = new_entry(r_word(7'h00, 5'd5, 5'd0, 3'd0, 5'd4, OPC_OP), 32'h104,
                  32'd0, rf_model[5], 32'd0, 5'd4);
    add_entry("add_x0", e);
    e = new_entry(s_word(12'hFEC, 5'd7, 5'd6, 3'd2), 32'h108,
                  rf_model[6], rf_model[7], 32'hFFFF_FFEC, 5'd0);
    add_entry("sw", e);
    e = new_entry(r_word(7'h00, 5'd10, 5'd8, 3'd0, 5'd9, OPC_OP), 32'h140,
                  32'hE500_0001, rf_model[10], 32'd0, 5'd9);
    e.es = {5'd8, 32'hE500_0001};
    e.ms = {5'd8, 32'hA500_0002};
    e.ws = {5'd8, 32'h5500_0003};
    add_entry("bypass_es", e);
    e = new_entry(r_word(7'h00, 5'd10, 5'd8, 3'd0, 5'd9, OPC_OP), 32'h144,
                  32'hA500_0012, rf_model[10], 32'd0, 5'd9);
    e.es = {5'd0, 32'hE500_0011};  // rd 0 never forwards
    e.ms = {5'd8, 32'hA500_0012};
    e.ws = {5'd8, 32'h5500_0013};
    add_entry("bypass_ms", e);
    e = new_entry(r_word(7'h00, 5'd10, 5'd8, 3'd0, 5'd9, OPC_OP), 32'h148,
                  rf_model[8], rf_model[10], 32'd0, 5'd9);
    e.es = {5'd11, 32'hE500_0021};
    e.ms = {5'd12, 32'hA500_0022};
    e.ws = {5'd13, 32'h5500_0023};
    add_entry("bypass_none", e);
    e = new_entry(r_word(7'h00, 5'd13, 5'd12, 3'd0, 5'd14, OPC_OP), 32'h180,
                  rf_model[12], 32'hD00D_0013, 32'd0, 5'd14);
    e.es          = {5'd13, 32'hD00D_0013};
    e.load_sel    = 1'b1;
    e.mode        = M_STALL;
    e.follow_inst = INST_NOP;  // must not slip in while stalled
    add_entry("load_use", e);
    e = new_entry(r_word(7'h00, 5'd17, 5'd16, 3'd6, 5'd15, OPC_OP), 32'h1C0,
                  rf_model[16], rf_model[17], 32'd0, 5'd15);
    e.mode        = M_HOLD;
    e.follow_inst = INST_NOP;
    add_entry("backpressure", e);
    e = new_entry(b_word(13'd16, 5'd20, 5'd20, 3'd0), 32'h200,
                  rf_model[20], rf_model[20], 32'd16, 5'd0);
    e.mode        = M_FOLLOW;
    e.follow_inst = r_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd5, OPC_OP);
    e.exp_taken   = 1'b1;
    e.exp_target  = 32'h210;
    add_entry("beq_taken", e);
    e = new_entry(j_word(21'h800, 5'd1), 32'h300, 32'd0, 32'd0, 32'h800, 5'd1);
    e.mode        = M_FOLLOW;
    e.follow_inst = i_word(12'h010, 5'd3, 3'd0, 5'd6, OPC_OPIMM);
    e.exp_taken   = 1'b1;
    e.exp_target  = 32'hB00;
    add_entry("jal", e);
    e = new_entry(b_word(13'd8, 5'd21, 5'd21, 3'd1), 32'h400,
                  rf_model[21], rf_model[21], 32'd8, 5'd0);
    add_entry("bne_not", e);
    e = new_entry(u_word(20'hABCDE, 5'd22, OPC_LUI), 32'h440, 32'd0, 32'd0,
                  32'hABCD_E000, 5'd22);
    add_entry("lui", e);
    e = new_entry(u_word(20'h80001, 5'd23, OPC_AUIPC), 32'h480, 32'd0, 32'd0,
                  32'h8000_1000, 5'd23);
    add_entry("auipc", e);
    e = new_entry(i_word(12'hFFC, 5'd25, 3'd0, 5'd24, OPC_JALR), 32'h500,
                  rf_model[25], 32'd0, 32'hFFFF_FFFC, 5'd24);
    tgt          = (rf_model[25] + 32'hFFFF_FFFC) & 32'hFFFF_FFFE;  // lsb dropped
    e.exp_taken  = (tgt != e.fetch_pc);
    e.exp_target = tgt;
    add_entry("jalr", e);
    e = new_entry(i_word(12'h7FF, 5'd27, 3'd2, 5'd26, OPC_LOAD), 32'h540,
                  rf_model[27], 32'd0, 32'h0000_07FF, 5'd26);
    add_entry("lw", e);
    e = new_entry(i_word(12'hFFF, 5'd29, 3'd0, 5'd28, OPC_OPIMM), 32'h580,
                  rf_model[29], 32'd0, 32'hFFFF_FFFF, 5'd28);
    add_entry("addi", e);
    e = new_entry(32'h00A5_807F, 32'h5C0, 32'd0, 32'd0, 32'd0, 5'd0);
    e.exp_inv = 1'b1;
    add_entry("undefined", e);
  endtask

  task automatic check_outputs(input entry_t e);
    check_eq("o_ds_to_es_bus.rs1_data", o_ds_to_es_bus.rs1_data, e.exp_rs1);
    check_eq("o_ds_to_es_bus.rs2_data", o_ds_to_es_bus.rs2_data, e.exp_rs2);
    check_eq("o_ds_to_es_bus.imm", o_ds_to_es_bus.imm, e.exp_imm);
    check_eq("o_ds_to_es_bus.rd", 32'(o_ds_to_es_bus.rd), 32'(e.exp_rd));
    check_eq("o_ds_to_es_bus.pc", o_ds_to_es_bus.pc, e.pc);
    check_eq("o_ds_to_es_bus.ctrl.invalid", 32'(o_ds_to_es_bus.ctrl.invalid), 32'(e.exp_inv));
    if (e.exp_inv) begin
      check_eq("o_ds_to_es_bus.ctrl.gpr_wen", 32'(o_ds_to_es_bus.ctrl.gpr_wen), 32'd0);
    end
    check_eq("o_br_bus.taken", 32'(o_br_bus.taken), 32'(e.exp_taken));
    if (e.exp_taken) begin
      check_eq("o_br_bus.target", o_br_bus.target, e.exp_target);
    end
  endtask

  task automatic run_entry(input string name, input entry_t e);
    int        errs_before;
    bit        ok;
    ds_to_es_t held;
    errs_before = errors;
    @(negedge i_clk);
    i_fs_valid    = 1'b1;
    i_fs_bus      = {e.inst, e.pc};
    i_es_bypass   = e.es;
    i_ms_bypass   = e.ms;
    i_ws_bypass   = e.ws;
    i_es_load_sel = e.load_sel;
    i_es_allowin  = 1'b1;
    #1;
    wait_allowin(ok);
    if (!ok) begin
      $display("test %-12s timed out", name);
      tests_run++;
      tests_failed++;
      return;
    end
    @(posedge i_clk);
    @(negedge i_clk);
    i_fs_valid = (e.mode != M_PLAIN);  // fetch offers the next word
    i_fs_bus   = {e.follow_inst, e.fetch_pc};
    if (e.mode == M_HOLD) begin
      i_es_allowin = 1'b0;
    end
    #1;
    held = o_ds_to_es_bus;
    if (e.mode == M_STALL || e.mode == M_HOLD) begin
      repeat (3) begin
        check_eq("o_ds_to_es_valid", 32'(o_ds_to_es_valid), 32'(e.mode == M_HOLD));
        check_eq("o_ds_allowin", 32'(o_ds_allowin), 32'd0);
        checks++;
        assert (o_ds_to_es_bus === held) else begin
          errors++;
          $display("ERR o_ds_to_es_bus expected %h got %h", held, o_ds_to_es_bus);
        end
        @(negedge i_clk);
        #1;
      end
      @(negedge i_clk);
      i_fs_valid    = 1'b0;
      i_es_load_sel = 1'b0;
      i_es_allowin  = 1'b1;
      #1;
    end
    poll_out_valid(ok);
    if (!ok) begin
      $display("test %-12s timed out", name);
      tests_run++;
      tests_failed++;
      return;
    end
    check_outputs(e);
    if (e.mode == M_STALL) begin
      checks++;
      assert (o_ds_to_es_bus === held) else begin
        errors++;
        $display("ERR o_ds_to_es_bus expected %h got %h", held, o_ds_to_es_bus);
      end
    end
    if (e.mode == M_FOLLOW) begin
      // fall-through fetch goes in as a nop
      @(posedge i_clk);
      @(negedge i_clk);
      i_fs_valid = 1'b0;
      #1;
      poll_out_valid(ok);
      if (!ok) begin
        $display("test %-12s timed out", name);
        tests_run++;
        tests_failed++;
        return;
      end
      check_eq("o_ds_to_es_bus.rd", 32'(o_ds_to_es_bus.rd), 32'd0);
      check_eq("o_ds_to_es_bus.imm", o_ds_to_es_bus.imm, 32'd0);
      check_eq("o_ds_to_es_bus.rs1_data", o_ds_to_es_bus.rs1_data, 32'd0);
      check_eq("o_ds_to_es_bus.pc", o_ds_to_es_bus.pc, e.fetch_pc);
      check_eq("o_br_bus.taken", 32'(o_br_bus.taken), 32'd0);
    end
    report(name, errs_before);
  endtask

  initial begin
    int errs_before;
    errors         = 0;
    checks         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    timed_out      = 1'b0;
    i_rst_n        = 1'b0;
    i_fs_valid     = 1'b0;
    i_fs_bus       = '0;
    i_es_allowin   = 1'b1;
    i_ws_to_rf_bus = '0;
    i_es_bypass    = '0;
    i_ms_bypass    = '0;
    i_ws_bypass    = '0;
    i_es_load_sel  = 1'b0;
    void'($urandom(SEED));

    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
    #1;
    errs_before = errors;
    check_eq("o_ds_to_es_valid", 32'(o_ds_to_es_valid), 32'd0);
    check_eq("o_ds_allowin", 32'(o_ds_allowin), 32'd1);
    check_eq("o_br_bus.taken", 32'(o_br_bus.taken), 32'd0);
    report("reset", errs_before);

    fill_registers();
    build_table();
    for (int i = 0; i < table_q.size(); i++) begin
      run_entry(name_q[i], table_q[i]);
      if (timed_out) begin
        break;
      end
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/branch_unit.sv ====
// branch and jump resolve, target compute and redirect decision
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
  input  wire                          i_valid,
  input  wire [rv_id_pkg::XLEN-1:0]    i_pc,
  input  wire [rv_id_pkg::XLEN-1:0]    i_imm,
  input  wire [rv_id_pkg::XLEN-1:0]    i_rs1_data,
  input  wire [rv_id_pkg::XLEN-1:0]    i_rs2_data,
  input  rv_id_pkg::ctrl_t             i_ctrl,
  input  wire [rv_id_pkg::XLEN-1:0]    i_fetch_pc,
  output rv_id_pkg::br_bus_t           o_br
);
  import rv_id_pkg::*;

  logic            eq;
  logic            lt;
  logic            ltu;
  logic            cond;
  logic            redirect;
  logic [XLEN-1:0] target;

  assign eq  = i_rs1_data == i_rs2_data;
  assign lt  = $signed(i_rs1_data) < $signed(i_rs2_data);
  assign ltu = i_rs1_data < i_rs2_data;

  always_comb begin
    case (i_ctrl.br_func)
      3'b000:  cond = eq;    // beq
      3'b001:  cond = !eq;   // bne
      3'b100:  cond = lt;    // blt
      3'b101:  cond = !lt;   // bge
      3'b110:  cond = ltu;   // bltu
      3'b111:  cond = !ltu;  // bgeu
      default: cond = 1'b0;
    endcase
  end

  always_comb begin
    if (i_ctrl.jalr) begin
      target = (i_rs1_data + i_imm) & ~32'd1;
    end else begin
      target = i_pc + i_imm;
    end
  end

  assign redirect = (i_ctrl.br_en && cond) || i_ctrl.jal || i_ctrl.jalr;

  // no redirect when fetch already sits on the target
  assign o_br.taken  = i_valid && redirect && (target != i_fetch_pc);
  assign o_br.target = target;

endmodule

`default_nettype wire

// ==== hdl/gpr_file.sv ====
// 32x32 general purpose register file, two async reads, one sync write
`timescale 1ns/1ps
`default_nettype none

module gpr_file (
  input  wire                            i_clk,
  input  wire                            i_rst_n,
  input  wire [rv_id_pkg::REG_AW-1:0]    i_raddr1,
  input  wire [rv_id_pkg::REG_AW-1:0]    i_raddr2,
  output logic [rv_id_pkg::XLEN-1:0]     o_rdata1,
  output logic [rv_id_pkg::XLEN-1:0]     o_rdata2,
  input  rv_id_pkg::rf_wr_t              i_wr
);
  import rv_id_pkg::*;

  logic [XLEN-1:0] regs [NREGS];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr.wen && (i_wr.waddr != '0)) begin  // x0 stays zero
      regs[i_wr.waddr] <= i_wr.wdata;
    end
  end

  // no write-through, ws bypass covers same-cycle writes
  assign o_rdata1 = regs[i_raddr1];
  assign o_rdata2 = regs[i_raddr2];

  a_x0_zero: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    ((i_raddr1 == '0) |-> (o_rdata1 == '0)) and ((i_raddr2 == '0) |-> (o_rdata2 == '0))
  ) else $error("x0 read returned nonzero data");

endmodule

`default_nettype wire

// ==== hdl/id_decoder.sv ====
// rv32i instruction decoder, control fields and sign-extended immediate
`timescale 1ns/1ps
`default_nettype none

module id_decoder (
  input  rv_id_pkg::inst_u                i_inst,
  output logic [rv_id_pkg::REG_AW-1:0]    o_rs1,
  output logic [rv_id_pkg::REG_AW-1:0]    o_rs2,
  output logic [rv_id_pkg::REG_AW-1:0]    o_rd,
  output logic [rv_id_pkg::XLEN-1:0]      o_imm,
  output rv_id_pkg::ctrl_t                o_ctrl
);
  import rv_id_pkg::*;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [2:0]      funct3;
  logic            alt;      // funct7[5], sub / sra
  logic            use_rs1;
  logic            use_rs2;
  logic            f3_bad;

  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt_sel);
    alu_op_e op;
    case (f3)
      3'd0: op = alt_sel ? ALU_SUB : ALU_ADD;
      3'd1: op = ALU_SLL;
      3'd2: op = ALU_SLT;
      3'd3: op = ALU_SLTU;
      3'd4: op = ALU_XOR;
      3'd5: op = alt_sel ? ALU_SRA : ALU_SRL;
      3'd6: op = ALU_OR;
      3'd7: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign funct3 = i_inst.r_fmt.funct3;
  assign alt    = i_inst.r_fmt.funct7[5];

  assign imm_i = {{20{i_inst.i_fmt.imm11_0[11]}}, i_inst.i_fmt.imm11_0};
  assign imm_s = {{20{i_inst.s_fmt.imm11_5[6]}}, i_inst.s_fmt.imm11_5, i_inst.s_fmt.imm4_0};
  assign imm_b = {{19{i_inst.b_fmt.imm12}}, i_inst.b_fmt.imm12, i_inst.b_fmt.imm11,
                  i_inst.b_fmt.imm10_5, i_inst.b_fmt.imm4_1, 1'b0};
  assign imm_u = {i_inst.u_fmt.imm31_12, 12'b0};
  assign imm_j = {{11{i_inst.j_fmt.imm20}}, i_inst.j_fmt.imm20, i_inst.j_fmt.imm19_12,
                  i_inst.j_fmt.imm11, i_inst.j_fmt.imm10_1, 1'b0};

  always_comb begin
    o_ctrl  = '0;
    o_imm   = '0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    f3_bad  = 1'b0;
    case (i_inst.r_fmt.opcode)
      OPC_LUI: begin
        o_ctrl.alu_op   = ALU_LUI;
        o_ctrl.src2_imm = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
        o_imm           = imm_u;
      end
      OPC_AUIPC: begin
        o_ctrl.src1_pc  = 1'b1;
        o_ctrl.src2_imm = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
        o_imm           = imm_u;
      end
      OPC_JAL: begin
        o_ctrl.src1_pc = 1'b1;  // link value pc+4 formed in execute
        o_ctrl.jal     = 1'b1;
        o_ctrl.gpr_wen = 1'b1;
        o_imm          = imm_j;
      end
      OPC_JALR: begin
        use_rs1        = 1'b1;
        o_ctrl.src1_pc = 1'b1;
        o_ctrl.jalr    = 1'b1;
        o_ctrl.gpr_wen = 1'b1;
        o_imm          = imm_i;
      end
      OPC_BRANCH: begin
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
        o_ctrl.br_en   = 1'b1;
        o_ctrl.br_func = funct3;
        o_imm          = imm_b;
        f3_bad         = (funct3 == 3'd2) || (funct3 == 3'd3);
      end
      OPC_LOAD: begin
        use_rs1         = 1'b1;
        o_ctrl.src2_imm = 1'b1;
        o_ctrl.mem_ren  = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.mem_op   = funct3;
        o_imm           = imm_i;
        f3_bad          = (funct3 == 3'd3) || (funct3 >= 3'd6);  // lb lh lw lbu lhu only
      end
      OPC_STORE: begin
        use_rs1         = 1'b1;
        use_rs2         = 1'b1;
        o_ctrl.src2_imm = 1'b1;
        o_ctrl.mem_wen  = 1'b1;
        o_ctrl.mem_op   = funct3;
        o_imm           = imm_s;
        f3_bad          = funct3 > 3'd2;
      end
      OPC_OPIMM: begin
        use_rs1         = 1'b1;
        o_ctrl.src2_imm = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.alu_op   = alu_from_f3(funct3, (funct3 == 3'd5) && alt);  // srai only
        o_imm           = imm_i;
      end
      OPC_OP: begin
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
        o_ctrl.gpr_wen = 1'b1;
        o_ctrl.alu_op  = alu_from_f3(funct3, alt);
      end
      default: o_ctrl.invalid = 1'b1;
    endcase

    if (f3_bad) o_ctrl.invalid = 1'b1;
    if (o_ctrl.invalid) begin
      o_ctrl.gpr_wen = 1'b0;
      o_ctrl.mem_ren = 1'b0;
      o_ctrl.mem_wen = 1'b0;
      o_ctrl.br_en   = 1'b0;
    end
  end

  // unused fields read as x0 so they never hit a bypass or a stall
  assign o_rs1 = use_rs1 ? i_inst.r_fmt.rs1 : '0;
  assign o_rs2 = use_rs2 ? i_inst.r_fmt.rs2 : '0;
  assign o_rd  = o_ctrl.gpr_wen ? i_inst.r_fmt.rd : '0;

endmodule

`default_nettype wire

// ==== hdl/id_stage.sv ====
// rv32i decode stage top, stage register, handshake and operand read
`timescale 1ns/1ps
`default_nettype none

module id_stage (
  input  wire                    i_clk,
  input  wire                    i_rst_n,
  input  wire                    i_fs_valid,
  input  rv_id_pkg::fs_to_ds_t   i_fs_bus,
  output logic                   o_ds_allowin,
  output logic                   o_ds_to_es_valid,
  output rv_id_pkg::ds_to_es_t   o_ds_to_es_bus,
  input  wire                    i_es_allowin,
  output rv_id_pkg::br_bus_t     o_br_bus,
  input  rv_id_pkg::rf_wr_t      i_ws_to_rf_bus,
  input  rv_id_pkg::bypass_t     i_es_bypass,
  input  rv_id_pkg::bypass_t     i_ms_bypass,
  input  rv_id_pkg::bypass_t     i_ws_bypass,
  input  wire                    i_es_load_sel
);
  import rv_id_pkg::*;

  logic              ds_valid;
  logic              ds_ready_go;
  fs_to_ds_t         fs_to_ds_r;   // held instruction and pc
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [REG_AW-1:0] rd;
  logic [XLEN-1:0]   imm;
  ctrl_t             ctrl;
  logic [XLEN-1:0]   rf_rdata1;
  logic [XLEN-1:0]   rf_rdata2;
  logic [XLEN-1:0]   rs1_data;
  logic [XLEN-1:0]   rs2_data;
  logic              load_stall;

  assign ds_ready_go      = !load_stall;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      if (o_br_bus.taken) begin
        fs_to_ds_r.inst <= INST_NOP;  // squash the fall-through fetch
      end else begin
        fs_to_ds_r.inst <= i_fs_bus.inst;
      end
      fs_to_ds_r.pc <= i_fs_bus.pc;
    end
  end

  id_decoder u_decoder (
    .i_inst  (fs_to_ds_r.inst),
    .o_rs1   (rs1),
    .o_rs2   (rs2),
    .o_rd    (rd),
    .o_imm   (imm),
    .o_ctrl  (ctrl)
  );

  gpr_file u_gprs (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_raddr1  (rs1),
    .i_raddr2  (rs2),
    .o_rdata1  (rf_rdata1),
    .o_rdata2  (rf_rdata2),
    .i_wr      (i_ws_to_rf_bus)
  );

  operand_bypass u_bypass (
    .i_rs1          (rs1),
    .i_rs2          (rs2),
    .i_rf_rdata1    (rf_rdata1),
    .i_rf_rdata2    (rf_rdata2),
    .i_es           (i_es_bypass),
    .i_ms           (i_ms_bypass),
    .i_ws           (i_ws_bypass),
    .i_es_load_sel  (i_es_load_sel),
    .o_rs1_data     (rs1_data),
    .o_rs2_data     (rs2_data),
    .o_load_stall   (load_stall)
  );

  // operands are stale while stalled on a load, hold off the compare
  branch_unit u_bru (
    .i_valid     (ds_valid && ds_ready_go),
    .i_pc        (fs_to_ds_r.pc),
    .i_imm       (imm),
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .i_ctrl      (ctrl),
    .i_fetch_pc  (i_fs_bus.pc),
    .o_br        (o_br_bus)
  );

  always_comb begin
    o_ds_to_es_bus.ctrl     = ctrl;
    o_ds_to_es_bus.rd       = rd;
    o_ds_to_es_bus.pc       = fs_to_ds_r.pc;
    o_ds_to_es_bus.rs1_data = rs1_data;
    o_ds_to_es_bus.rs2_data = rs2_data;
    o_ds_to_es_bus.imm      = imm;
  end

  // a squashed fetch leaves decode as a harmless bubble
  a_squash_nop: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_fs_valid && o_ds_allowin && o_br_bus.taken) |=>
      (ds_valid && (o_ds_to_es_bus.rd == '0) && !o_ds_to_es_bus.ctrl.mem_ren &&
       !o_ds_to_es_bus.ctrl.mem_wen && !o_ds_to_es_bus.ctrl.br_en &&
       !o_ds_to_es_bus.ctrl.jal && !o_ds_to_es_bus.ctrl.jalr)
  ) else $error("squashed fetch did not become a nop");

  a_hold_stable: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (o_ds_to_es_valid && !i_es_allowin) |=> (o_ds_to_es_valid && $stable(o_ds_to_es_bus))
  ) else $error("output bus changed under back-pressure");

endmodule

`default_nettype wire

// ==== hdl/operand_bypass.sv ====
// operand forwarding from es/ms/ws and load-use hazard detect
`timescale 1ns/1ps
`default_nettype none

module operand_bypass (
  input  wire [rv_id_pkg::REG_AW-1:0]  i_rs1,
  input  wire [rv_id_pkg::REG_AW-1:0]  i_rs2,
  input  wire [rv_id_pkg::XLEN-1:0]    i_rf_rdata1,
  input  wire [rv_id_pkg::XLEN-1:0]    i_rf_rdata2,
  input  rv_id_pkg::bypass_t           i_es,
  input  rv_id_pkg::bypass_t           i_ms,
  input  rv_id_pkg::bypass_t           i_ws,
  input  wire                          i_es_load_sel,
  output logic [rv_id_pkg::XLEN-1:0]   o_rs1_data,
  output logic [rv_id_pkg::XLEN-1:0]   o_rs2_data,
  output logic                         o_load_stall
);
  import rv_id_pkg::*;

  // youngest producer wins
  function automatic logic [XLEN-1:0] fwd(
    input logic [REG_AW-1:0] rs,
    input logic [XLEN-1:0]   rf_data,
    input bypass_t           es,
    input bypass_t           ms,
    input bypass_t           ws
  );
    logic [XLEN-1:0] data;
    if ((es.rd != '0) && (es.rd == rs)) begin
      data = es.result;
    end else if ((ms.rd != '0) && (ms.rd == rs)) begin
      data = ms.result;
    end else if ((ws.rd != '0) && (ws.rd == rs)) begin
      data = ws.result;
    end else begin
      data = rf_data;
    end
    return data;
  endfunction

  assign o_rs1_data = fwd(i_rs1, i_rf_rdata1, i_es, i_ms, i_ws);
  assign o_rs2_data = fwd(i_rs2, i_rf_rdata2, i_es, i_ms, i_ws);

  // load data only exists once es hands it to ms
  assign o_load_stall = i_es_load_sel && (i_es.rd != '0) &&
                        ((i_es.rd == i_rs1) || (i_es.rd == i_rs2));

endmodule

`default_nettype wire

// ==== hdl/rv_id_pkg.sv ====
// rv32i decode stage shared widths, opcodes and bus types
`default_nettype none

package rv_id_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;
  localparam int NREGS  = 32;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  localparam logic [31:0] INST_NOP = 32'h00000013;  // addi x0, x0, 0

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  // branch offset bits are scattered, bit 0 implied
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_u;

  typedef struct packed {
    inst_u            inst;
    logic [XLEN-1:0]  pc;
  } fs_to_ds_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI
  } alu_op_e;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       src1_pc;   // pc as operand 1
    logic       src2_imm;  // imm as operand 2
    logic       gpr_wen;
    logic       mem_ren;
    logic       mem_wen;
    logic [2:0] mem_op;    // load/store funct3
    logic       br_en;
    logic [2:0] br_func;   // branch funct3
    logic       jal;
    logic       jalr;
    logic       invalid;
  } ctrl_t;

  typedef struct packed {
    ctrl_t             ctrl;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   imm;
  } ds_to_es_t;

  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target;
  } br_bus_t;

  typedef struct packed {
    logic              wen;
    logic [REG_AW-1:0] waddr;
    logic [XLEN-1:0]   wdata;
  } rf_wr_t;

  typedef struct packed {
    logic [REG_AW-1:0] rd;      // 0 when nothing to forward
    logic [XLEN-1:0]   result;
  } bypass_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the decode stage testbench with Verilator, run it, judge by the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert -j 0 --top-module tb_id_stage -Mdir "$OBJ" -o tb_id_stage -f src.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/tb_id_stage" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== src.f ====
hdl/rv_id_pkg.sv
hdl/id_decoder.sv
hdl/gpr_file.sv
hdl/operand_bypass.sv
hdl/branch_unit.sv
hdl/id_stage.sv
dv/tb_id_stage.sv
